// ==== Bender.yml ====
package:
  name: wb_xbar

export_include_dirs:
  - include

sources:
  - files:
      - source/wb_bus_pkg.sv
      - source/wb_xbar_pkg.sv
      - source/wb_master_port.sv
      - source/wb_rr_arbiter.sv
      - source/wb_decode_err_slave.sv
      - source/wb_xbar_switch.sv
      - source/wb_xbar_top.sv
  - target: simulation
    files:
      - dv/tb_wb_xbar.sv

// ==== dv/tb_wb_xbar.sv ====
// Run from the project root so dv/wb_xbar_golden.txt is found; lines of one group need distinct masters
`include "wb_xbar_consts.svh"

module tb_wb_xbar;

	timeunit 1ns;
	timeprecision 100ps;

	// Golden table capacity
	localparam int MAX_LINES = 64;

	logic clk = 1'b0;
	logic rstn;

	wb_bus_pkg::wb_req_t mst_req [`XBAR_N_MASTERS];
	wb_bus_pkg::wb_rsp_t mst_rsp [`XBAR_N_MASTERS];
	wb_bus_pkg::wb_req_t slv_req [`XBAR_N_SLAVES];
	wb_bus_pkg::wb_rsp_t slv_rsp [`XBAR_N_SLAVES];

	// Golden columns, one entry per transaction
	int n_lines;
	int g_mst [MAX_LINES];
	int g_we [MAX_LINES];
	logic [`WB_ADDR_W-1:0] g_adr [MAX_LINES];
	logic [`WB_DATA_W-1:0] g_wdat [MAX_LINES];
	logic [`WB_SEL_W-1:0] g_sel [MAX_LINES];
	logic [`WB_DATA_W-1:0] g_rdat [MAX_LINES];
	int g_err [MAX_LINES];
	int g_grp [MAX_LINES];

	// Order in which each slave port must see requests, as line indices
	int slv_list [`XBAR_N_SLAVES][MAX_LINES];
	int slv_cnt [`XBAR_N_SLAVES];
	int slv_pos [`XBAR_N_SLAVES];

	// Line each master runs in the current group, -1 when none
	int cur_line [`XBAR_N_MASTERS];

	// Word memories behind the slave ports
	logic [`WB_DATA_W-1:0] mem [`XBAR_N_SLAVES][16384];

	int cycles = 0;
	int limit = 0;

	wb_xbar_top dut_i (
		.clk (clk),
		.rstn (rstn),
		.mst_req_i (mst_req),
		.mst_rsp_o (mst_rsp),
		.slv_req_o (slv_req),
		.slv_rsp_i (slv_rsp)
	);

	always #4 clk = ~clk;

	// Prints the reason, then the fail verdict, then stops
	task automatic report_failure(input string line);
		$display("%s", line);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_rsp(input wb_bus_pkg::wb_rsp_t exp, input wb_bus_pkg::wb_rsp_t got,
		input string what);
		if (got !== exp) begin
			report_failure($sformatf("Mismatch at time %0t: %s, expected %h, got %h",
				$time, what, exp, got));
		end
	endtask

	task automatic check_req(input wb_bus_pkg::wb_req_t exp, input wb_bus_pkg::wb_req_t got,
		input string what);
		if (got !== exp) begin
			report_failure($sformatf("Mismatch at time %0t: %s, expected %h, got %h",
				$time, what, exp, got));
		end
	endtask

	// Slave index of an address from the memory map, -1 when unmapped
	function automatic int window_of(input logic [`WB_ADDR_W-1:0] adr);
		if (adr >= `XBAR_S0_BASE && adr <= `XBAR_S0_LIMIT) begin
			return 0;
		end
		if (adr >= `XBAR_S1_BASE && adr <= `XBAR_S1_LIMIT) begin
			return 1;
		end
		if (adr >= `XBAR_S2_BASE && adr <= `XBAR_S2_LIMIT) begin
			return 2;
		end
		return -1;
	endfunction

	// Request a golden line puts on the bus
	function automatic wb_bus_pkg::wb_req_t line_req(input int k);
		wb_bus_pkg::wb_req_t req;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = g_we[k] != 0;
		req.sel = g_sel[k];
		req.adr = g_adr[k];
		req.dat_w = g_wdat[k];
		return req;
	endfunction

	// Nonzero filler, so a leak to a master without a grant shows up
	function automatic wb_bus_pkg::wb_rsp_t idle_rsp(input int s);
		wb_bus_pkg::wb_rsp_t rsp;
		rsp.ack = 1'b0;
		rsp.err = 1'b0;
		rsp.dat_r = 32'hbad0_0000 + s;
		return rsp;
	endfunction

	task automatic load_golden();
		int fd;
		int cnt;
		int s;
		int mst;
		int we;
		int err;
		int grp;
		logic [31:0] adr;
		logic [31:0] wdat;
		logic [31:0] sel;
		logic [31:0] rdat;
		string text;
		n_lines = 0;
		fd = $fopen("dv/wb_xbar_golden.txt", "r");
		if (fd == 0) begin
			report_failure("Could not open the golden file dv/wb_xbar_golden.txt");
		end
		while (!$feof(fd) && $fgets(text, fd) != 0) begin
			// Skip blank and comment lines
			if (text.len() < 2 || text.getc(0) == "#") begin
				continue;
			end
			cnt = $sscanf(text, "%d %d %h %h %h %h %d %d", mst, we, adr, wdat, sel, rdat,
				err, grp);
			if (cnt != 8 || mst < 0 || mst >= `XBAR_N_MASTERS || n_lines >= MAX_LINES) begin
				report_failure($sformatf("Golden file line is malformed: %s", text));
			end
			g_mst[n_lines] = mst;
			g_we[n_lines] = we;
			g_adr[n_lines] = adr;
			g_wdat[n_lines] = wdat;
			g_sel[n_lines] = sel[`WB_SEL_W-1:0];
			g_rdat[n_lines] = rdat;
			g_err[n_lines] = err;
			g_grp[n_lines] = grp;
			// File order within a slave is the expected arrival order
			s = window_of(adr);
			if (s >= 0) begin
				slv_list[s][slv_cnt[s]] = n_lines;
				slv_cnt[s]++;
			end
			n_lines++;
		end
		$fclose(fd);
	endtask

	// Word memory that acks each request after 0 to 3 cycles
	task automatic serve_slave(input int s);
		int k;
		int w;
		int delay;
		wb_bus_pkg::wb_req_t got;
		forever begin
			@(posedge clk);
			got = slv_req[s];
			if (got.cyc && got.stb) begin
				if (slv_pos[s] >= slv_cnt[s]) begin
					report_failure($sformatf("Slave %0d got a request that no golden line sends", s));
				end
				k = slv_list[s][slv_pos[s]];
				slv_pos[s]++;
				check_req(line_req(k), got, $sformatf("slave %0d request for line %0d", s, k));
				w = int'(got.adr[15:2]);
				delay = $urandom_range(3, 0);
				repeat (delay) @(posedge clk);
				#1;
				if (got.we) begin
					for (int b = 0; b < `WB_SEL_W; b++) begin
						if (got.sel[b]) begin
							mem[s][w][8*b +: 8] = got.dat_w[8*b +: 8];
						end
					end
					slv_rsp[s] = '{ack: 1'b1, err: 1'b0, dat_r: '0};
				end else begin
					slv_rsp[s] = '{ack: 1'b1, err: 1'b0, dat_r: mem[s][w]};
				end
				// Ack is taken on this edge
				@(posedge clk);
				#1;
				slv_rsp[s] = idle_rsp(s);
			end
		end
	endtask

	// Runs one golden line on master m and checks what it sees meanwhile
	task automatic drive_master(input int m);
		int k;
		int s;
		bit done;
		wb_bus_pkg::wb_req_t req;
		wb_bus_pkg::wb_rsp_t got;
		wb_bus_pkg::wb_rsp_t exp;
		k = cur_line[m];
		if (k >= 0) begin
			req = line_req(k);
			s = window_of(g_adr[k]);
			exp.ack = g_err[k] == 0;
			exp.err = g_err[k] != 0;
			exp.dat_r = g_rdat[k];
			@(posedge clk);
			#1;
			mst_req[m] = req;
			done = 1'b0;
			while (!done) begin
				@(posedge clk);
				got = mst_rsp[m];
				if (got.ack || got.err) begin
					done = 1'b1;
				end else if (s < 0 || slv_req[s] !== req) begin
					// Slave busy with someone else, nothing may leak through
					check_rsp('0, got, $sformatf("master %0d while waiting", m));
				end
			end
			#1;
			mst_req[m] = '0;
			check_rsp(exp, got, $sformatf("master %0d response for line %0d", m, k));
		end
	endtask

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			report_failure($sformatf("Run timed out after %0d cycles", limit));
		end
	end

	initial begin
		int k;
		int g;
		int missed;
		rstn = 1'b0;
		for (int m = 0; m < `XBAR_N_MASTERS; m++) begin
			mst_req[m] = '0;
		end
		for (int s = 0; s < `XBAR_N_SLAVES; s++) begin
			slv_rsp[s] = idle_rsp(s);
			slv_cnt[s] = 0;
			slv_pos[s] = 0;
		end
		void'($urandom(8));
		load_golden();
		limit = 40 * n_lines + 100;
		fork
			serve_slave(0);
			serve_slave(1);
			serve_slave(2);
		join_none
		repeat (3) @(posedge clk);
		#1;
		rstn = 1'b1;
		// Everything idle right after reset
		@(posedge clk);
		for (int s = 0; s < `XBAR_N_SLAVES; s++) begin
			check_req('0, slv_req[s], $sformatf("slave %0d after reset", s));
		end
		for (int m = 0; m < `XBAR_N_MASTERS; m++) begin
			check_rsp('0, mst_rsp[m], $sformatf("master %0d after reset", m));
		end
		k = 0;
		while (k < n_lines) begin
			g = g_grp[k];
			for (int m = 0; m < `XBAR_N_MASTERS; m++) begin
				cur_line[m] = -1;
			end
			// Gather the group, one line per master
			while (k < n_lines && g_grp[k] == g) begin
				if (cur_line[g_mst[k]] >= 0) begin
					report_failure($sformatf("Group %0d uses master %0d twice", g, g_mst[k]));
				end
				cur_line[g_mst[k]] = k;
				k++;
			end
			fork
				drive_master(0);
				drive_master(1);
				drive_master(2);
				drive_master(3);
			join
		end
		repeat (4) @(posedge clk);
		missed = 0;
		for (int s = 0; s < `XBAR_N_SLAVES; s++) begin
			if (slv_pos[s] != slv_cnt[s]) begin
				missed++;
			end
		end
		if (missed != 0) begin
			report_failure($sformatf("%0d slave ports never saw all of their requests", missed));
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

// ==== dv/wb_xbar_golden.txt ====
# master we addr wdata sel exp_dat_r exp_err group
# master, we, exp_err and group are decimal, the rest hex; a group runs at once
0 1 00000010 11111111 f 00000000 0 0
0 0 00000010 00000000 f 11111111 0 1
1 1 00001004 22222222 f 00000000 0 2
1 0 00001004 00000000 f 22222222 0 3
2 1 00010020 33333333 f 00000000 0 4
2 0 00010020 00000000 f 33333333 0 5
3 0 00002000 00000000 f 00000000 1 6
0 1 00020000 44444444 f 00000000 1 6
1 0 fffffff0 00000000 f 00000000 1 7
3 1 00001100 30303030 f 00000000 0 8
0 1 00001200 a0a0a0a0 f 00000000 0 9
1 1 00001204 a1a1a1a1 f 00000000 0 9
2 1 00001208 a2a2a2a2 f 00000000 0 9
3 1 0000120c a3a3a3a3 f 00000000 0 9
1 0 00001204 00000000 f a1a1a1a1 0 10
2 0 00001208 00000000 f a2a2a2a2 0 11
3 0 0000120c 00000000 f a3a3a3a3 0 11
0 0 00001200 00000000 f a0a0a0a0 0 11
1 0 00001204 00000000 f a1a1a1a1 0 11
0 0 00010020 00000000 f 33333333 0 12
1 0 00000010 00000000 f 11111111 0 12
2 0 00001100 00000000 f 30303030 0 12
3 0 00008000 00000000 f 00000000 1 12
2 1 00000010 00005555 3 00000000 0 13
3 0 00000010 00000000 f 11115555 0 14
1 0 00010020 00000000 f 33333333 0 14

// ==== include/wb_xbar_consts.svh ====
// Bus widths, port counts and slave windows; windows are inclusive and must not overlap
`ifndef WB_XBAR_CONSTS_SVH
`define WB_XBAR_CONSTS_SVH

// Wishbone address and data widths
`define WB_ADDR_W 32
`define WB_DATA_W 32

// One byte-select bit per data byte
`define WB_SEL_W (`WB_DATA_W / 8 * 2 / 2)

// Crossbar port counts
`define XBAR_N_MASTERS 4
`define XBAR_N_SLAVES 3

// Real slaves plus the decode-error target
`define XBAR_N_TARGETS (`XBAR_N_SLAVES + 1)

// Slave 0 window, 4 KiB at the bottom of the map
`define XBAR_S0_BASE 32'h0000_0000
`define XBAR_S0_LIMIT 32'h0000_0FFF

// Slave 1 window, the next 4 KiB
`define XBAR_S1_BASE 32'h0000_1000
`define XBAR_S1_LIMIT 32'h0000_1FFF

// Slave 2 window, 64 KiB
// The gap below it is unmapped
`define XBAR_S2_BASE 32'h0001_0000
`define XBAR_S2_LIMIT 32'h0001_FFFF

`endif

// ==== project.f ====
+incdir+include
source/wb_bus_pkg.sv
source/wb_xbar_pkg.sv
source/wb_master_port.sv
source/wb_rr_arbiter.sv
source/wb_decode_err_slave.sv
source/wb_xbar_switch.sv
source/wb_xbar_top.sv
dv/tb_wb_xbar.sv

// ==== source/wb_bus_pkg.sv ====
// Classic Wishbone single transfers only; no CTI/BTE burst tags are carried
`include "wb_xbar_consts.svh"

package wb_bus_pkg;

	// Master to slave direction
	// Held steady by the master until ack or err
	typedef struct packed {
		// Bus cycle in progress
		logic cyc;
		// Valid transfer on this cycle
		logic stb;
		// Write when high, read when low
		logic we;
		// Byte lanes taking part
		logic [`WB_SEL_W-1:0] sel;
		// Byte address
		logic [`WB_ADDR_W-1:0] adr;
		// Write data
		logic [`WB_DATA_W-1:0] dat_w;
	} wb_req_t;

	// Slave to master direction
	// Only one of ack and err may be high
	typedef struct packed {
		// Transfer done normally
		logic ack;
		// Transfer done with error
		logic err;
		// Read data, valid with ack on reads
		logic [`WB_DATA_W-1:0] dat_r;
	} wb_rsp_t;

endpackage

// ==== source/wb_decode_err_slave.sv ====
// Answers every transfer with a one-cycle err; writes are dropped and read data is zero
module wb_decode_err_slave (
	input logic clk,
	input logic rstn,
	input wb_bus_pkg::wb_req_t req_i,
	output wb_bus_pkg::wb_rsp_t rsp_o
);

	// Registered error strobe
	logic err_q;

	// Transfer waiting for an answer
	logic hit;

	// Skip the cycle in which err is already up
	// so a held stb is answered once
	assign hit = req_i.cyc & req_i.stb & ~err_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			err_q <= hit;
		end
	end

	// Never acks, never returns data
	assign rsp_o.ack = 1'b0;
	assign rsp_o.err = err_q;
	assign rsp_o.dat_r = '0;

	// Once err has reached the master the switch gates the request off
	// The next cycle must see no transfer here
	a_req_gone_after_err: assert property (
		@(posedge clk) disable iff (!rstn)
		err_q |=> !(req_i.cyc && req_i.stb)
	) else $error("request still presented after err");

endmodule

// ==== source/wb_master_port.sv ====
// Route is taken from the first stb of a cycle and held until ack or err; a dropped cyc does not clear it
`include "wb_xbar_consts.svh"

module wb_master_port (
	input logic clk,
	input logic rstn,
	input wb_bus_pkg::wb_req_t req_i,
	input wb_bus_pkg::wb_rsp_t rsp_i,
	output wb_xbar_pkg::route_t route_o
);

	// Current route, valid bit is the tracker state
	wb_xbar_pkg::route_t route_q;

	// Response seen by this master ends the transfer
	logic done;

	// Window lookup
	// First match wins, unmapped goes to the error target
	function automatic wb_xbar_pkg::target_id_t decode(input logic [`WB_ADDR_W-1:0] adr);
		wb_xbar_pkg::target_id_t tgt;
		tgt = wb_xbar_pkg::target_id_t'(`XBAR_N_SLAVES);
		if (adr >= `XBAR_S0_BASE && adr <= `XBAR_S0_LIMIT) begin
			tgt = wb_xbar_pkg::target_id_t'(0);
		end else if (adr >= `XBAR_S1_BASE && adr <= `XBAR_S1_LIMIT) begin
			tgt = wb_xbar_pkg::target_id_t'(1);
		end else if (adr >= `XBAR_S2_BASE && adr <= `XBAR_S2_LIMIT) begin
			tgt = wb_xbar_pkg::target_id_t'(2);
		end
		return tgt;
	endfunction

	assign done = rsp_i.ack | rsp_i.err;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			route_q <= '0;
		end else if (!route_q.valid) begin
			// Idle, wait for a new transfer
			if (req_i.cyc && req_i.stb) begin
				route_q.valid <= 1'b1;
				route_q.tgt <= decode(req_i.adr);
			end
		end else if (done) begin
			// Busy, release on the master's own response
			route_q <= '0;
		end
	end

	assign route_o = route_q;

	// Held route must keep matching the address the master holds
	// The arbiter and switch both index with it
	a_route_held: assert property (
		@(posedge clk) disable iff (!rstn)
		route_q.valid |-> route_q.tgt == decode(req_i.adr)
	) else $error("route no longer matches the held address");

endmodule

// ==== source/wb_rr_arbiter.sv ====
// One grant at a time, held until the owner's request drops; N_REQ must fit in master_id_t
module wb_rr_arbiter #(
	parameter int N_REQ = 4
) (
	input logic clk,
	input logic rstn,
	input logic [N_REQ-1:0] req_i,
	output logic gnt_o,
	output wb_xbar_pkg::master_id_t gnt_id_o
);

	// Grant held flag
	logic gnt_q;

	// Owner while granted, last owner otherwise
	wb_xbar_pkg::master_id_t gnt_id_q;

	// Lowest requester overall
	wb_xbar_pkg::master_id_t pick_low;

	// Lowest requester above the last grant
	wb_xbar_pkg::master_id_t pick_above;
	logic found_above;

	// Winner for the next grant
	wb_xbar_pkg::master_id_t pick;

	// Owner still asking
	logic owner_req;

	always_comb begin
		pick_low = '0;
		pick_above = '0;
		found_above = 1'b0;
		// Walk downward so the lowest index is the last written
		for (int i = N_REQ - 1; i >= 0; i--) begin
			if (req_i[i]) begin
				pick_low = wb_xbar_pkg::master_id_t'(i);
			end
			if (req_i[i] && i > int'(gnt_id_q)) begin
				pick_above = wb_xbar_pkg::master_id_t'(i);
				found_above = 1'b1;
			end
		end
		// Wrap to the bottom when nobody is above the last owner
		pick = found_above ? pick_above : pick_low;
	end

	assign owner_req = req_i[gnt_id_q];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_q <= 1'b0;
			// Start as if the top master had the last grant
			// so master 0 wins first
			gnt_id_q <= wb_xbar_pkg::master_id_t'(N_REQ - 1);
		end else if (!gnt_q) begin
			if (|req_i) begin
				gnt_q <= 1'b1;
				gnt_id_q <= pick;
			end
		end else if (!owner_req) begin
			// Owner released, one idle cycle follows
			gnt_q <= 1'b0;
		end
	end

	assign gnt_o = gnt_q;
	assign gnt_id_o = gnt_id_q;

	// New grant goes to a master that asked on the previous cycle
	a_gnt_to_req: assert property (
		@(posedge clk) disable iff (!rstn)
		$rose(gnt_q) |-> ((($past(req_i)) >> gnt_id_q) & N_REQ'(1)) != '0
	) else $error("grant given to a master without a request");

	// Owner is fixed for the whole tenure
	a_gnt_id_stable: assert property (
		@(posedge clk) disable iff (!rstn)
		gnt_q |=> !gnt_q || $stable(gnt_id_q)
	) else $error("grant id changed while held");

endmodule

// ==== source/wb_xbar_pkg.sv ====
// Crossbar bookkeeping types; the last target index is always the decode-error target
`include "wb_xbar_consts.svh"

package wb_xbar_pkg;

	// Index of a master port
	typedef logic [$clog2(`XBAR_N_MASTERS)-1:0] master_id_t;

	// Index of a target
	// Slaves first, decode-error target last
	typedef logic [$clog2(`XBAR_N_TARGETS)-1:0] target_id_t;

	// Route of one master for the current bus cycle
	typedef struct packed {
		// Master owns a decoded route
		logic valid;
		// Target that the cycle goes to
		target_id_t tgt;
	} route_t;

endpackage

// ==== source/wb_xbar_switch.sv ====
// Pure combinational routing; a target or master without a matching grant sees all zeros
`include "wb_xbar_consts.svh"

module wb_xbar_switch (
	input wb_bus_pkg::wb_req_t mst_req_i [`XBAR_N_MASTERS],
	input wb_bus_pkg::wb_rsp_t tgt_rsp_i [`XBAR_N_TARGETS],
	input wb_xbar_pkg::route_t route_i [`XBAR_N_MASTERS],
	input logic [`XBAR_N_TARGETS-1:0] gnt_i,
	input wb_xbar_pkg::master_id_t gnt_id_i [`XBAR_N_TARGETS],
	output wb_bus_pkg::wb_req_t tgt_req_o [`XBAR_N_TARGETS],
	output wb_bus_pkg::wb_rsp_t mst_rsp_o [`XBAR_N_MASTERS]
);

	// Per master, targets that end a transfer for it this cycle
	logic [`XBAR_N_MASTERS-1:0][`XBAR_N_TARGETS-1:0] rsp_hit;

	// Request path, one mux per target
	for (genvar t = 0; t < `XBAR_N_TARGETS; t++) begin : g_tgt
		wb_xbar_pkg::master_id_t owner;
		logic fwd;

		assign owner = gnt_id_i[t];

		// Owner must still hold a route to this target
		// Blocks a new request in the cycle before the grant drops
		assign fwd = gnt_i[t] && route_i[owner].valid &&
			route_i[owner].tgt == wb_xbar_pkg::target_id_t'(t);

		assign tgt_req_o[t] = fwd ? mst_req_i[owner] : '0;
	end

	// Response path, one mux per master
	for (genvar m = 0; m < `XBAR_N_MASTERS; m++) begin : g_mst
		wb_xbar_pkg::target_id_t tgt;
		logic own;

		assign tgt = route_i[m].tgt;

		// Routed target is granted to this master
		assign own = route_i[m].valid && gnt_i[tgt] &&
			gnt_id_i[tgt] == wb_xbar_pkg::master_id_t'(m);

		assign mst_rsp_o[m] = own ? tgt_rsp_i[tgt] : '0;

		// Raw view from the targets, independent of routes
		for (genvar t = 0; t < `XBAR_N_TARGETS; t++) begin : g_hit
			assign rsp_hit[m][t] = gnt_i[t] &&
				gnt_id_i[t] == wb_xbar_pkg::master_id_t'(m) &&
				(tgt_rsp_i[t].ack || tgt_rsp_i[t].err);
		end

		// Arbiters must never hand one master to two targets
		// at a time when both are answering
		always_comb begin
			a_one_rsp: assert final ($countones(rsp_hit[m]) <= 1)
				else $error("master %0d answered by several targets", m);
		end
	end

endmodule

// ==== source/wb_xbar_top.sv ====
// Four masters, three slaves, unmapped addresses end in err; stb reaches a slave two edges late
`include "wb_xbar_consts.svh"

module wb_xbar_top (
	input logic clk,
	input logic rstn,
	input wb_bus_pkg::wb_req_t mst_req_i [`XBAR_N_MASTERS],
	output wb_bus_pkg::wb_rsp_t mst_rsp_o [`XBAR_N_MASTERS],
	output wb_bus_pkg::wb_req_t slv_req_o [`XBAR_N_SLAVES],
	input wb_bus_pkg::wb_rsp_t slv_rsp_i [`XBAR_N_SLAVES]
);

	// Routes held by the master ports
	wb_xbar_pkg::route_t route [`XBAR_N_MASTERS];

	// Per target, one request bit per master
	logic [`XBAR_N_MASTERS-1:0] tgt_req_vec [`XBAR_N_TARGETS];

	// Arbiter results
	logic [`XBAR_N_TARGETS-1:0] tgt_gnt;
	wb_xbar_pkg::master_id_t tgt_gnt_id [`XBAR_N_TARGETS];

	// Target side of the switch, slaves then the error target
	wb_bus_pkg::wb_req_t tgt_req [`XBAR_N_TARGETS];
	wb_bus_pkg::wb_rsp_t tgt_rsp [`XBAR_N_TARGETS];

	for (genvar m = 0; m < `XBAR_N_MASTERS; m++) begin : g_port
		wb_master_port port_i (
			.clk (clk),
			.rstn (rstn),
			.req_i (mst_req_i[m]),
			.rsp_i (mst_rsp_o[m]),
			.route_o (route[m])
		);
	end

	for (genvar t = 0; t < `XBAR_N_TARGETS; t++) begin : g_arb
		// Masters whose live route names this target
		for (genvar m = 0; m < `XBAR_N_MASTERS; m++) begin : g_vec
			assign tgt_req_vec[t][m] = route[m].valid &&
				route[m].tgt == wb_xbar_pkg::target_id_t'(t);
		end

		wb_rr_arbiter #(
			.N_REQ (`XBAR_N_MASTERS)
		) arb_i (
			.clk (clk),
			.rstn (rstn),
			.req_i (tgt_req_vec[t]),
			.gnt_o (tgt_gnt[t]),
			.gnt_id_o (tgt_gnt_id[t])
		);
	end

	wb_xbar_switch switch_i (
		.mst_req_i (mst_req_i),
		.tgt_rsp_i (tgt_rsp),
		.route_i (route),
		.gnt_i (tgt_gnt),
		.gnt_id_i (tgt_gnt_id),
		.tgt_req_o (tgt_req),
		.mst_rsp_o (mst_rsp_o)
	);

	// Real slaves on the low target indices
	for (genvar s = 0; s < `XBAR_N_SLAVES; s++) begin : g_slv
		assign slv_req_o[s] = tgt_req[s];
		assign tgt_rsp[s] = slv_rsp_i[s];
	end

	// Last target catches unmapped addresses
	wb_decode_err_slave err_i (
		.clk (clk),
		.rstn (rstn),
		.req_i (tgt_req[`XBAR_N_SLAVES]),
		.rsp_o (tgt_rsp[`XBAR_N_SLAVES])
	);

endmodule
